/* Makefile */
TOP = tb_mips_cpu_bus

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee run.log
	grep -q "TEST PASSED" run.log

clean:
	rm -rf obj_dir run.log

/* logic/alu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module alu (
    input  cpu_pkg::op_t           op,
    input  logic [`CPU_WORD_W-1:0] a,
    input  logic [`CPU_WORD_W-1:0] b,
    input  logic [4:0]             shamt,
    output logic [`CPU_WORD_W-1:0] result,
    output cpu_pkg::alu_flags_t    flags
);

    always_comb begin
        flags.equal = (a == b);
        if (op == cpu_pkg::OP_SLTU) begin
            flags.less = (a < b);
        end else begin
            flags.less = ($signed(a) < $signed(b));
        end
    end

    always_comb begin
        case (op)
            cpu_pkg::OP_SUBU:                   result = a - b;
            cpu_pkg::OP_AND, cpu_pkg::OP_ANDI:  result = a & b;
            cpu_pkg::OP_OR, cpu_pkg::OP_ORI:    result = a | b;
            cpu_pkg::OP_XOR, cpu_pkg::OP_XORI:  result = a ^ b;
            cpu_pkg::OP_SLT, cpu_pkg::OP_SLTU: begin
                result = {{(`CPU_WORD_W-1){1'b0}}, flags.less};
            end
            // Shifts work on rt, which arrives on b
            cpu_pkg::OP_SLL:                    result = b << shamt;
            cpu_pkg::OP_SRL:                    result = b >> shamt;
            cpu_pkg::OP_SRA:                    result = $signed(b) >>> shamt;
            cpu_pkg::OP_LUI:                    result = b << 16;
            // Add also forms the load/store effective address
            default:                            result = a + b;
        endcase
    end

endmodule

`default_nettype wire

/* logic/bus_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module bus_unit (
    input  cpu_pkg::step_t         step,
    input  cpu_pkg::decoded_t      decoded,
    input  logic [`CPU_WORD_W-1:0] pc,
    input  logic [`CPU_WORD_W-1:0] mem_addr,
    input  logic [`CPU_WORD_W-1:0] store_data,
    input  logic                   waitrequest,
    input  logic [`CPU_WORD_W-1:0] readdata,
    output logic [`CPU_WORD_W-1:0] address,
    output logic [`CPU_WORD_W-1:0] writedata,
    output logic [`CPU_WORD_W-1:0] load_data,
    output logic [`CPU_WORD_W-1:0] instr,
    output logic                   instr_valid,
    output logic                   stall,
    output logic                   read,
    output logic                   write,
    output logic [3:0]             byteenable
);

    logic                   fetch;
    logic                   mem_step;
    logic                   byte_load;
    logic [`CPU_WORD_W-1:0] rd_swapped;
    logic [7:0]             lane_byte;

    assign fetch     = (step == cpu_pkg::STEP_FETCH);
    assign mem_step  = (step == cpu_pkg::STEP_MEM);
    assign byte_load = (decoded.op == cpu_pkg::OP_LB) || (decoded.op == cpu_pkg::OP_LBU);

    assign read  = fetch || (mem_step && decoded.is_load);
    assign write = mem_step && decoded.is_store;
    assign stall = (read || write) && waitrequest;

    // Data accesses go out word aligned, the lane is picked by byteenable
    assign address    = fetch ? pc : {mem_addr[`CPU_WORD_W-1:2], 2'b00};
    assign byteenable = (mem_step && byte_load) ? (4'b0001 << mem_addr[1:0]) : 4'b1111;

    // Big-endian words on byte-reversed lanes
    assign rd_swapped = {readdata[7:0], readdata[15:8], readdata[23:16], readdata[31:24]};
    assign writedata  = {store_data[7:0], store_data[15:8], store_data[23:16], store_data[31:24]};
    assign lane_byte  = readdata[{mem_addr[1:0], 3'b000} +: 8];

    assign instr       = rd_swapped;
    assign instr_valid = fetch && !waitrequest;

    always_comb begin
        case (decoded.op)
            cpu_pkg::OP_LB:  load_data = {{(`CPU_WORD_W-8){lane_byte[7]}}, lane_byte};
            cpu_pkg::OP_LBU: load_data = {{(`CPU_WORD_W-8){1'b0}}, lane_byte};
            default:         load_data = rd_swapped;
        endcase
    end

endmodule

`default_nettype wire

/* logic/cpu_defs.svh */
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// Data path and bus width
`define CPU_WORD_W 32

// First instruction fetched after reset
`define CPU_RESET_VECTOR 32'hBFC00000

// Jumping here stops the core
`define CPU_HALT_ADDR 32'h00000000

`endif

/* logic/cpu_pkg.sv */
`default_nettype none

`include "cpu_defs.svh"

package cpu_pkg;

    typedef enum logic [4:0] {
        OP_NOP,
        OP_ADDU,
        OP_ADDIU,
        OP_SUBU,
        OP_AND,
        OP_ANDI,
        OP_OR,
        OP_ORI,
        OP_XOR,
        OP_XORI,
        OP_SLT,
        OP_SLTU,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_LUI,
        OP_LW,
        OP_LB,
        OP_LBU,
        OP_SW,
        OP_BEQ,
        OP_BNE,
        OP_J,
        OP_JAL,
        OP_JR
    } op_t;

    typedef struct packed {
        op_t                    op;
        logic [4:0]             rs;
        logic [4:0]             rt;
        logic [4:0]             rd;
        logic [4:0]             shamt;
        logic [`CPU_WORD_W-1:0] imm_ext;
        logic [25:0]            target;
        logic                   writes_reg;
        logic [4:0]             dest;
        logic                   uses_imm;
        logic                   is_load;
        logic                   is_store;
    } decoded_t;

    typedef struct packed {
        logic equal;
        logic less;
    } alu_flags_t;

    typedef enum logic [1:0] {
        STEP_FETCH,
        STEP_EXEC,
        STEP_MEM,
        STEP_HALT
    } step_t;

endpackage

`default_nettype wire

/* logic/cpu_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_sequencer (
    input  logic           clk,
    input  logic           arst_n,
    input  logic           stall,
    input  logic           halt_req,
    output cpu_pkg::step_t step
);

    cpu_pkg::step_t step_next;

    always_comb begin
        step_next = step;
        if (!stall) begin
            case (step)
                cpu_pkg::STEP_FETCH: step_next = cpu_pkg::STEP_EXEC;
                cpu_pkg::STEP_EXEC:  step_next = cpu_pkg::STEP_MEM;
                cpu_pkg::STEP_MEM:   step_next = halt_req ? cpu_pkg::STEP_HALT
                                                          : cpu_pkg::STEP_FETCH;
                default:             step_next = cpu_pkg::STEP_HALT;
            endcase
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            step <= cpu_pkg::STEP_FETCH;
        end else begin
            step <= step_next;
        end
    end

    // Halt is terminal until the next reset
    a_halt_sticky: assert property (@(posedge clk) disable iff (!arst_n)
        step == cpu_pkg::STEP_HALT |=> step == cpu_pkg::STEP_HALT);

endmodule

`default_nettype wire

/* logic/instr_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module instr_decoder (
    input  logic                   clk,
    input  logic                   arst_n,
    input  cpu_pkg::step_t         step,
    input  logic [`CPU_WORD_W-1:0] instr,
    input  logic                   instr_valid,
    output cpu_pkg::decoded_t      decoded
);

    logic [`CPU_WORD_W-1:0] ir;
    cpu_pkg::op_t           op;

    // Instruction register, all zero decodes as a harmless sll to r0
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ir <= '0;
        end else if (step == cpu_pkg::STEP_FETCH && instr_valid) begin
            ir <= instr;
        end
    end

    always_comb begin
        op = cpu_pkg::OP_NOP;
        case (ir[31:26])
            6'h00: begin
                case (ir[5:0])
                    6'h00: op = cpu_pkg::OP_SLL;
                    6'h02: op = cpu_pkg::OP_SRL;
                    6'h03: op = cpu_pkg::OP_SRA;
                    6'h08: op = cpu_pkg::OP_JR;
                    6'h21: op = cpu_pkg::OP_ADDU;
                    6'h23: op = cpu_pkg::OP_SUBU;
                    6'h24: op = cpu_pkg::OP_AND;
                    6'h25: op = cpu_pkg::OP_OR;
                    6'h26: op = cpu_pkg::OP_XOR;
                    6'h2A: op = cpu_pkg::OP_SLT;
                    6'h2B: op = cpu_pkg::OP_SLTU;
                    default: op = cpu_pkg::OP_NOP;
                endcase
            end
            6'h02: op = cpu_pkg::OP_J;
            6'h03: op = cpu_pkg::OP_JAL;
            6'h04: op = cpu_pkg::OP_BEQ;
            6'h05: op = cpu_pkg::OP_BNE;
            6'h09: op = cpu_pkg::OP_ADDIU;
            6'h0C: op = cpu_pkg::OP_ANDI;
            6'h0D: op = cpu_pkg::OP_ORI;
            6'h0E: op = cpu_pkg::OP_XORI;
            6'h0F: op = cpu_pkg::OP_LUI;
            6'h20: op = cpu_pkg::OP_LB;
            6'h23: op = cpu_pkg::OP_LW;
            6'h24: op = cpu_pkg::OP_LBU;
            6'h2B: op = cpu_pkg::OP_SW;
            default: op = cpu_pkg::OP_NOP;
        endcase
    end

    always_comb begin
        decoded            = '0;
        decoded.op         = op;
        decoded.rs         = ir[25:21];
        decoded.rt         = ir[20:16];
        decoded.rd         = ir[15:11];
        decoded.shamt      = ir[10:6];
        decoded.target     = ir[25:0];
        decoded.dest       = ir[20:16];
        decoded.imm_ext    = {{(`CPU_WORD_W-16){ir[15]}}, ir[15:0]};
        case (op)
            cpu_pkg::OP_ANDI, cpu_pkg::OP_ORI, cpu_pkg::OP_XORI: begin
                // Logical immediates are zero extended
                decoded.imm_ext    = {{(`CPU_WORD_W-16){1'b0}}, ir[15:0]};
                decoded.uses_imm   = 1'b1;
                decoded.writes_reg = 1'b1;
            end
            cpu_pkg::OP_ADDIU, cpu_pkg::OP_LUI: begin
                decoded.uses_imm   = 1'b1;
                decoded.writes_reg = 1'b1;
            end
            cpu_pkg::OP_LW, cpu_pkg::OP_LB, cpu_pkg::OP_LBU: begin
                decoded.uses_imm   = 1'b1;
                decoded.writes_reg = 1'b1;
                decoded.is_load    = 1'b1;
            end
            cpu_pkg::OP_SW: begin
                decoded.uses_imm = 1'b1;
                decoded.is_store = 1'b1;
            end
            cpu_pkg::OP_JAL: begin
                decoded.writes_reg = 1'b1;
                decoded.dest       = 5'd31;
            end
            cpu_pkg::OP_NOP, cpu_pkg::OP_JR, cpu_pkg::OP_J,
            cpu_pkg::OP_BEQ, cpu_pkg::OP_BNE: begin
                decoded.writes_reg = 1'b0;
            end
            default: begin
                // R-type ALU operations
                decoded.writes_reg = 1'b1;
                decoded.dest       = ir[15:11];
            end
        endcase
    end

endmodule

`default_nettype wire

/* logic/mips_cpu_bus.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module mips_cpu_bus (
    input  logic                   clk,
    input  logic                   arst_n,
    output logic                   active,
    output logic [`CPU_WORD_W-1:0] register_v0,

    // Avalon master
    output logic [`CPU_WORD_W-1:0] address,
    output logic                   write,
    output logic                   read,
    input  logic                   waitrequest,
    output logic [`CPU_WORD_W-1:0] writedata,
    output logic [3:0]             byteenable,
    input  logic [`CPU_WORD_W-1:0] readdata
);

    cpu_pkg::step_t         step;
    cpu_pkg::decoded_t      decoded;
    cpu_pkg::alu_flags_t    flags;
    logic                   stall;
    logic                   halt_req;
    logic                   instr_valid;
    logic                   reg_we;
    logic                   bus_read;
    logic [`CPU_WORD_W-1:0] instr;
    logic [`CPU_WORD_W-1:0] rda;
    logic [`CPU_WORD_W-1:0] rdb;
    logic [`CPU_WORD_W-1:0] op_b;
    logic [`CPU_WORD_W-1:0] alu_result;
    logic [`CPU_WORD_W-1:0] load_data;
    logic [`CPU_WORD_W-1:0] wb_data;
    logic [`CPU_WORD_W-1:0] pc;
    logic [`CPU_WORD_W-1:0] return_addr;

    assign active = (step != cpu_pkg::STEP_HALT);
    assign op_b   = decoded.uses_imm ? decoded.imm_ext : rdb;
    assign reg_we = (step == cpu_pkg::STEP_MEM) && !stall && decoded.writes_reg;

    // Bus stays idle while reset is held
    assign read = bus_read && arst_n;

    always_comb begin
        if (decoded.is_load) begin
            wb_data = load_data;
        end else if (decoded.op == cpu_pkg::OP_JAL) begin
            wb_data = return_addr;
        end else begin
            wb_data = alu_result;
        end
    end

    cpu_sequencer u_sequencer (
        .clk(clk), .arst_n(arst_n), .stall(stall), .halt_req(halt_req), .step(step)
    );

    instr_decoder u_decoder (
        .clk(clk), .arst_n(arst_n), .step(step), .instr(instr),
        .instr_valid(instr_valid), .decoded(decoded)
    );

    alu u_alu (
        .op(decoded.op), .a(rda), .b(op_b), .shamt(decoded.shamt),
        .result(alu_result), .flags(flags)
    );

    reg_file u_reg_file (
        .clk(clk), .arst_n(arst_n), .we(reg_we), .ra(decoded.rs), .rb(decoded.rt),
        .wa(decoded.dest), .wd(wb_data), .rda(rda), .rdb(rdb), .v0(register_v0)
    );

    program_counter u_pc (
        .clk(clk), .arst_n(arst_n), .step(step), .decoded(decoded), .flags(flags),
        .rs_value(rda), .pc(pc), .return_addr(return_addr), .halt_req(halt_req)
    );

    bus_unit u_bus (
        .step(step), .decoded(decoded), .pc(pc), .mem_addr(alu_result),
        .store_data(rdb), .waitrequest(waitrequest), .readdata(readdata),
        .address(address), .writedata(writedata), .load_data(load_data),
        .instr(instr), .instr_valid(instr_valid), .stall(stall),
        .read(bus_read), .write(write), .byteenable(byteenable)
    );

    // Whole request held while the slave waits
    a_bus_hold: assert property (@(posedge clk) disable iff (!arst_n)
        (read || write) && waitrequest |=>
            $stable({address, read, write, writedata, byteenable}));

    // No bus traffic once halted
    a_quiet_halt: assert property (@(posedge clk) disable iff (!arst_n)
        !active |-> !read && !write);

endmodule

`default_nettype wire

/* logic/program_counter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module program_counter (
    input  logic                   clk,
    input  logic                   arst_n,
    input  cpu_pkg::step_t         step,
    input  cpu_pkg::decoded_t      decoded,
    input  cpu_pkg::alu_flags_t    flags,
    input  logic [`CPU_WORD_W-1:0] rs_value,
    output logic [`CPU_WORD_W-1:0] pc,
    output logic [`CPU_WORD_W-1:0] return_addr,
    output logic                   halt_req
);

    logic [`CPU_WORD_W-1:0] pc_plus4;
    logic [`CPU_WORD_W-1:0] next_pc;
    logic [`CPU_WORD_W-1:0] ret_q;

    assign pc_plus4 = pc + `CPU_WORD_W'd4;

    always_comb begin
        next_pc = pc_plus4;
        case (decoded.op)
            cpu_pkg::OP_BEQ: begin
                if (flags.equal) begin
                    next_pc = pc_plus4 + {decoded.imm_ext[`CPU_WORD_W-3:0], 2'b00};
                end
            end
            cpu_pkg::OP_BNE: begin
                if (!flags.equal) begin
                    next_pc = pc_plus4 + {decoded.imm_ext[`CPU_WORD_W-3:0], 2'b00};
                end
            end
            cpu_pkg::OP_J, cpu_pkg::OP_JAL: begin
                next_pc = {pc_plus4[`CPU_WORD_W-1:`CPU_WORD_W-4], decoded.target, 2'b00};
            end
            cpu_pkg::OP_JR: next_pc = rs_value;
            default: next_pc = pc_plus4;
        endcase
    end

    // Target is resolved in exec, which never waits, and is not fetched before mem ends
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= `CPU_RESET_VECTOR;
        end else if (step == cpu_pkg::STEP_EXEC) begin
            pc <= next_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (step == cpu_pkg::STEP_EXEC) begin
            ret_q <= pc_plus4;
        end
    end

    assign return_addr = ret_q;

    // During mem, pc already holds the next PC
    assign halt_req = (pc == `CPU_HALT_ADDR);

endmodule

`default_nettype wire

/* logic/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module reg_file (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   we,
    input  logic [4:0]             ra,
    input  logic [4:0]             rb,
    input  logic [4:0]             wa,
    input  logic [`CPU_WORD_W-1:0] wd,
    output logic [`CPU_WORD_W-1:0] rda,
    output logic [`CPU_WORD_W-1:0] rdb,
    output logic [`CPU_WORD_W-1:0] v0
);

    logic [`CPU_WORD_W-1:0] regs [32];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wa != 5'd0) begin
            regs[wa] <= wd;
        end
    end

    assign rda = regs[ra];
    assign rdb = regs[rb];
    // $v0 is r2
    assign v0  = regs[2];

endmodule

`default_nettype wire

/* verification/tb_avalon_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_avalon_memory (
    input  logic        clk,
    input  logic [31:0] address,
    input  logic        read,
    input  logic        write,
    input  logic [31:0] writedata,
    input  logic [3:0]  byteenable,
    output logic        waitrequest,
    output logic [31:0] readdata
);

    logic [7:0] bytes [logic [31:0]];

    // Unwritten bytes read back a pattern built from every address bit
    function automatic logic [7:0] byte_at(input logic [31:0] a);
        if (bytes.exists(a)) begin
            return bytes[a];
        end
        return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24];
    endfunction

    // Big-endian word with the MSB at the lowest address
    task automatic load_word(input logic [31:0] a, input logic [31:0] data);
        bytes[a]     = data[31:24];
        bytes[a + 1] = data[23:16];
        bytes[a + 2] = data[15:8];
        bytes[a + 3] = data[7:0];
    endtask

    initial begin
        waitrequest = 1'b0;
        readdata    = '0;
    end

    always @(posedge clk) begin
        if (write && !waitrequest) begin
            for (int i = 0; i < 4; i++) begin
                if (byteenable[i]) begin
                    bytes[address + i] = writedata[8*i +: 8];
                end
            end
            $display("[%0t] store 0x%08h data 0x%08h be %b",
                     $time, address, writedata, byteenable);
        end
        #1;
        waitrequest = ($urandom % 3) == 0;
        // Lane i carries the byte at address + i
        readdata = {byte_at(address + 3), byte_at(address + 2),
                    byte_at(address + 1), byte_at(address)};
    end

endmodule

`default_nettype wire

/* verification/tb_mips_cpu_bus.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module tb_mips_cpu_bus;

    localparam int CLK_PERIOD = 4;
    localparam int N_INSTR    = 47;
    localparam logic [31:0] BASE = `CPU_RESET_VECTOR;
    localparam logic [31:0] DATA_ADDR = BASE + 32'h100;

    logic        clk = 1'b0;
    logic        arst_n;
    logic        active;
    logic [31:0] register_v0;
    logic [31:0] address;
    logic        write;
    logic        read;
    logic        waitrequest;
    logic [31:0] writedata;
    logic [3:0]  byteenable;
    logic [31:0] readdata;

    int          value_errors = 0;
    int          other_errors = 0;
    logic [31:0] prog [$];
    logic [3:0]  load_lanes [$];
    logic [31:0] expected [logic [31:0]];
    bit          seen [logic [31:0]];
    bit          first_read_done = 1'b0;
    bit          held = 1'b0;
    logic [69:0] held_bus;
    logic [31:0] store_value;
    logic [3:0]  read_lanes;

    always #(CLK_PERIOD / 2) clk = ~clk;

    mips_cpu_bus u_dut (
        .clk(clk), .arst_n(arst_n), .active(active), .register_v0(register_v0),
        .address(address), .write(write), .read(read), .waitrequest(waitrequest),
        .writedata(writedata), .byteenable(byteenable), .readdata(readdata)
    );

    tb_avalon_memory u_mem (
        .clk(clk), .address(address), .read(read), .write(write),
        .writedata(writedata), .byteenable(byteenable),
        .waitrequest(waitrequest), .readdata(readdata)
    );

    function automatic logic [31:0] r_op(input int rs, rt, rd, sh, funct);
        return {6'h00, rs[4:0], rt[4:0], rd[4:0], sh[4:0], funct[5:0]};
    endfunction

    function automatic logic [31:0] i_op(input int op, rs, rt, input logic [15:0] imm);
        return {op[5:0], rs[4:0], rt[4:0], imm};
    endfunction

    function automatic logic [31:0] j_op(input int op, input int index);
        logic [31:0] dest;
        dest = BASE + 4 * index;
        return {op[5:0], dest[27:2]};
    endfunction

    // Compute with r8 and r9, store r10 to the result slot
    task automatic alu_and_store(input logic [31:0] instr, input logic [31:0] value);
        logic [31:0] slot;
        slot = 32'h200 + 4 * expected.num();
        prog.push_back(instr);
        prog.push_back(i_op(6'h2B, 16, 10, slot[15:0]));
        expected[BASE + slot] = value;
    endtask

    task automatic build_program;
        prog.push_back(i_op(6'h0F, 0, 16, 16'hBFC0));
        prog.push_back(i_op(6'h09, 0, 8, 16'hFFFB));
        prog.push_back(i_op(6'h0D, 0, 9, 16'h1234));
        alu_and_store(r_op(8, 9, 10, 0, 6'h21), 32'hFFFFFFFB + 32'h1234);
        alu_and_store(r_op(9, 8, 10, 0, 6'h23), 32'h1234 - 32'hFFFFFFFB);
        alu_and_store(r_op(8, 9, 10, 0, 6'h24), 32'h00001230);
        alu_and_store(r_op(8, 9, 10, 0, 6'h25), 32'hFFFFFFFF);
        alu_and_store(r_op(8, 9, 10, 0, 6'h26), 32'hFFFFEDCF);
        alu_and_store(r_op(8, 9, 10, 0, 6'h2A), 32'd1);
        alu_and_store(r_op(8, 9, 10, 0, 6'h2B), 32'd0);
        alu_and_store(r_op(0, 8, 10, 1, 6'h03), 32'hFFFFFFFD);
        alu_and_store(r_op(0, 8, 10, 4, 6'h02), 32'h0FFFFFFF);
        alu_and_store(r_op(0, 9, 10, 8, 6'h00), 32'h00123400);
        alu_and_store(i_op(6'h0C, 8, 10, 16'hFF00), 32'h0000FF00);
        alu_and_store(i_op(6'h0E, 9, 10, 16'hFFFF), 32'h0000EDCB);
        // Loads write r10 so the same store slot pattern applies
        alu_and_store(i_op(6'h23, 16, 10, 16'h0100), 32'h80FF1234);
        load_lanes.push_back(4'b1111);
        alu_and_store(i_op(6'h20, 16, 10, 16'h0100), 32'hFFFFFF80);
        load_lanes.push_back(4'b0001);
        alu_and_store(i_op(6'h24, 16, 10, 16'h0101), 32'h000000FF);
        load_lanes.push_back(4'b0010);
        prog.push_back(i_op(6'h04, 8, 8, 16'h0001));
        prog.push_back(i_op(6'h2B, 16, 0, 16'h02F0));
        prog.push_back(i_op(6'h05, 8, 8, 16'h0001));
        alu_and_store(i_op(6'h09, 0, 10, 16'h0011), 32'h00000011);
        prog.push_back(j_op(6'h02, 40));
        prog.push_back(i_op(6'h2B, 16, 0, 16'h02F4));
        prog.push_back(j_op(6'h03, 43));
        prog.push_back(i_op(6'h2B, 16, 15, 16'h0244));
        prog.push_back(r_op(0, 0, 0, 0, 6'h08));
        prog.push_back(i_op(6'h09, 0, 15, 16'h0022));
        prog.push_back(i_op(6'h2B, 16, 31, 16'h0248));
        prog.push_back(i_op(6'h09, 0, 2, 16'h005A));
        prog.push_back(r_op(31, 0, 0, 0, 6'h08));
        expected[BASE + 32'h244] = 32'h00000022;
        expected[BASE + 32'h248] = BASE + 4 * 41;
    endtask

    always @(posedge clk) begin
        if (arst_n) begin
            assert (!(read && write)) else begin
                other_errors++;
                $display("Bus error at %0t: read and write both high", $time);
            end
            if (held) begin
                assert ({address, read, write, writedata, byteenable} == held_bus) else begin
                    other_errors++;
                    $display("Bus error at %0t: request changed during waitrequest", $time);
                end
            end
            held     = (read || write) && waitrequest;
            held_bus = {address, read, write, writedata, byteenable};
            if (!active) begin
                assert (!read && !write) else begin
                    other_errors++;
                    $display("Bus error at %0t: bus access after halt", $time);
                end
            end
            if (read && !waitrequest) begin
                read_lanes = 4'b1111;
                if (!first_read_done) begin
                    first_read_done = 1'b1;
                    assert (address == `CPU_RESET_VECTOR) else begin
                        value_errors++;
                        $display("FAILED at %0t: first fetch from 0x%08h", $time, address);
                    end
                end
                if (address == DATA_ADDR) begin
                    if (load_lanes.size() == 0) begin
                        other_errors++;
                        $display("Unexpected data read of 0x%08h at %0t", address, $time);
                    end else begin
                        read_lanes = load_lanes.pop_front();
                    end
                end
                assert (byteenable == read_lanes) else begin
                    value_errors++;
                    $display("FAILED at %0t: read of 0x%08h byteenable %b expected %b",
                             $time, address, byteenable, read_lanes);
                end
            end
            if (write && !waitrequest) begin
                store_value = {writedata[7:0], writedata[15:8], writedata[23:16],
                               writedata[31:24]};
                assert (byteenable == 4'hF) else begin
                    value_errors++;
                    $display("FAILED at %0t: word store byteenable %b", $time, byteenable);
                end
                if (expected.exists(address)) begin
                    seen[address] = 1'b1;
                    assert (store_value == expected[address]) else begin
                        value_errors++;
                        $display("FAILED at %0t: 0x%08h got 0x%08h expected 0x%08h",
                                 $time, address, store_value, expected[address]);
                    end
                end else begin
                    other_errors++;
                    $display("Store to 0x%08h at %0t is on a wrong path", address, $time);
                end
            end
        end
    end

    initial begin
        #(N_INSTR * 40 * 4 * CLK_PERIOD);
        $display("Timeout: core did not halt within the time limit");
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        void'($urandom(57084));
        arst_n = 1'b0;
        build_program();
        for (int i = 0; i < prog.size(); i++) begin
            u_mem.load_word(BASE + 4 * i, prog[i]);
        end
        u_mem.load_word(DATA_ADDR, 32'h80FF1234);
        repeat (2) @(posedge clk);
        assert (active && !read && !write) else begin
            other_errors++;
            $display("Core not idle and active during reset");
        end
        #1 arst_n = 1'b1;
        wait (!active);
        repeat (10) @(posedge clk);
        assert (register_v0 == 32'h0000005A) else begin
            value_errors++;
            $display("FAILED at %0t: register_v0 0x%08h", $time, register_v0);
        end
        foreach (expected[a]) begin
            if (!seen.exists(a)) begin
                other_errors++;
                $display("No store reached result address 0x%08h", a);
            end
        end
        $display("Errors: %0d total, %0d value, %0d other",
                 value_errors + other_errors, value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+logic
logic/cpu_pkg.sv
logic/cpu_sequencer.sv
logic/instr_decoder.sv
logic/alu.sv
logic/reg_file.sv
logic/program_counter.sv
logic/bus_unit.sv
logic/mips_cpu_bus.sv
verification/tb_avalon_memory.sv
verification/tb_mips_cpu_bus.sv
